/* source/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

    localparam int wordWidth    = 32;
    localparam int opWidth      = 6;
    localparam int functWidth   = 6;
    localparam int regAddrWidth = 5;
    localparam int immWidth     = 16;
    localparam int targetWidth  = 26;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////
    localparam logic [opWidth-1:0] opSpecial  = 6'h00;  // Funct decides
    localparam logic [opWidth-1:0] opRegImm   = 6'h01;  // Rt decides
    localparam logic [opWidth-1:0] opJ        = 6'h02;
    localparam logic [opWidth-1:0] opJal      = 6'h03;
    localparam logic [opWidth-1:0] opBeq      = 6'h04;
    localparam logic [opWidth-1:0] opBne      = 6'h05;
    localparam logic [opWidth-1:0] opBlez     = 6'h06;
    localparam logic [opWidth-1:0] opBgtz     = 6'h07;
    localparam logic [opWidth-1:0] opAddi     = 6'h08;
    localparam logic [opWidth-1:0] opAddiu    = 6'h09;
    localparam logic [opWidth-1:0] opSlti     = 6'h0a;
    localparam logic [opWidth-1:0] opSltiu    = 6'h0b;
    localparam logic [opWidth-1:0] opAndi     = 6'h0c;
    localparam logic [opWidth-1:0] opOri      = 6'h0d;
    localparam logic [opWidth-1:0] opXori     = 6'h0e;
    localparam logic [opWidth-1:0] opLui      = 6'h0f;
    localparam logic [opWidth-1:0] opSpecial2 = 6'h1c;  // MUL
    localparam logic [opWidth-1:0] opSpecial3 = 6'h1f;  // SEB, SEH
    localparam logic [opWidth-1:0] opLb       = 6'h20;
    localparam logic [opWidth-1:0] opLh       = 6'h21;
    localparam logic [opWidth-1:0] opLw       = 6'h23;
    localparam logic [opWidth-1:0] opSb       = 6'h28;
    localparam logic [opWidth-1:0] opSh       = 6'h29;
    localparam logic [opWidth-1:0] opSw       = 6'h2b;

    ////////////////////////////////////////
    // Function codes
    ////////////////////////////////////////
    localparam logic [functWidth-1:0] fnSll   = 6'h00;
    localparam logic [functWidth-1:0] fnSrl   = 6'h02;  // ROTR when rs[0] set
    localparam logic [functWidth-1:0] fnSra   = 6'h03;
    localparam logic [functWidth-1:0] fnSllv  = 6'h04;
    localparam logic [functWidth-1:0] fnSrlv  = 6'h06;  // ROTRV when sa[0] set
    localparam logic [functWidth-1:0] fnSrav  = 6'h07;
    localparam logic [functWidth-1:0] fnJr    = 6'h08;
    localparam logic [functWidth-1:0] fnMovz  = 6'h0a;
    localparam logic [functWidth-1:0] fnMovn  = 6'h0b;
    localparam logic [functWidth-1:0] fnAdd   = 6'h20;
    localparam logic [functWidth-1:0] fnAddu  = 6'h21;
    localparam logic [functWidth-1:0] fnSub   = 6'h22;
    localparam logic [functWidth-1:0] fnAnd   = 6'h24;
    localparam logic [functWidth-1:0] fnOr    = 6'h25;
    localparam logic [functWidth-1:0] fnXor   = 6'h26;
    localparam logic [functWidth-1:0] fnNor   = 6'h27;
    localparam logic [functWidth-1:0] fnSlt   = 6'h2a;
    localparam logic [functWidth-1:0] fnSltu  = 6'h2b;
    localparam logic [functWidth-1:0] fnMul   = 6'h02;  // Under opSpecial2
    localparam logic [functWidth-1:0] fnBshfl = 6'h20;  // Under opSpecial3

    localparam logic [regAddrWidth-1:0] rtBltz = 5'h00;
    localparam logic [regAddrWidth-1:0] rtBgez = 5'h01;
    localparam logic [regAddrWidth-1:0] saSeb  = 5'h10;
    localparam logic [regAddrWidth-1:0] saSeh  = 5'h18;

    typedef struct packed {
        logic [opWidth-1:0]      opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] shamt;
        logic [functWidth-1:0]   funct;
    } rFormat_s;

    typedef struct packed {
        logic [opWidth-1:0]      opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [immWidth-1:0]     imm;
    } iFormat_s;

    typedef struct packed {
        logic [opWidth-1:0]     opcode;
        logic [targetWidth-1:0] target;
    } jFormat_s;

    typedef union packed {
        rFormat_s r;
        iFormat_s i;
        jFormat_s j;
    } instrWord_u;

endpackage

`default_nettype wire

/* source/mipsCtrlPkg.sv */
`default_nettype none

package mipsCtrlPkg;

    localparam int aluOpWidth   = 6;
    localparam int memSizeWidth = 2;

    ////////////////////////////////////////
    // ALU operations, execute stage numbering
    ////////////////////////////////////////
    localparam logic [aluOpWidth-1:0] aluNone    = 6'd0;  // Nothing decoded
    localparam logic [aluOpWidth-1:0] aluAdd     = 6'd0;
    localparam logic [aluOpWidth-1:0] aluSub     = 6'd1;
    localparam logic [aluOpWidth-1:0] aluAnd     = 6'd2;
    localparam logic [aluOpWidth-1:0] aluOr      = 6'd3;
    localparam logic [aluOpWidth-1:0] aluNor     = 6'd4;
    localparam logic [aluOpWidth-1:0] aluXor     = 6'd5;
    localparam logic [aluOpWidth-1:0] aluSeh     = 6'd6;
    localparam logic [aluOpWidth-1:0] aluSll     = 6'd7;
    localparam logic [aluOpWidth-1:0] aluSrl     = 6'd8;
    localparam logic [aluOpWidth-1:0] aluSlt     = 6'd9;
    localparam logic [aluOpWidth-1:0] aluMovn    = 6'd10;
    localparam logic [aluOpWidth-1:0] aluMovz    = 6'd11;
    localparam logic [aluOpWidth-1:0] aluRotr    = 6'd12;
    localparam logic [aluOpWidth-1:0] aluSra     = 6'd13;
    localparam logic [aluOpWidth-1:0] aluSrav    = 6'd14;
    localparam logic [aluOpWidth-1:0] aluSeb     = 6'd15;
    localparam logic [aluOpWidth-1:0] aluSltiu   = 6'd16;
    localparam logic [aluOpWidth-1:0] aluSltu    = 6'd17;
    localparam logic [aluOpWidth-1:0] aluMul     = 6'd18;
    localparam logic [aluOpWidth-1:0] aluAddu    = 6'd23;
    localparam logic [aluOpWidth-1:0] aluBeq     = 6'd28;
    localparam logic [aluOpWidth-1:0] aluBne     = 6'd29;
    localparam logic [aluOpWidth-1:0] aluBgtz    = 6'd30;
    localparam logic [aluOpWidth-1:0] aluBlez    = 6'd31;
    localparam logic [aluOpWidth-1:0] aluBgez    = 6'd32;
    localparam logic [aluOpWidth-1:0] aluLui     = 6'd33;
    localparam logic [aluOpWidth-1:0] aluJr      = 6'd34;
    localparam logic [aluOpWidth-1:0] aluJal     = 6'd35;
    localparam logic [aluOpWidth-1:0] aluMemAddr = 6'd36;  // Base plus offset
    localparam logic [aluOpWidth-1:0] aluBltz    = 6'd37;
    localparam logic [aluOpWidth-1:0] aluJ       = 6'd38;

    ////////////////////////////////////////
    // Memory access size
    ////////////////////////////////////////
    localparam logic [memSizeWidth-1:0] memNone = 2'd0;
    localparam logic [memSizeWidth-1:0] memWord = 2'd1;
    localparam logic [memSizeWidth-1:0] memHalf = 2'd2;
    localparam logic [memSizeWidth-1:0] memByte = 2'd3;

endpackage

`default_nettype wire

/* source/aluOpDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module aluOpDecode
(
    input  mipsIsaPkg::instrWord_u               instr,
    output logic                                 hit,
    output logic [mipsCtrlPkg::aluOpWidth-1:0]   aluOp,
    output logic                                 regDst,
    output logic                                 aluSrcImm,
    output logic                                 shamtSrc,
    output logic                                 zeroExtImm
);

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    always_comb
    begin
        hit = 1'b1;
        aluOp = aluNone;
        regDst = 1'b0;
        aluSrcImm = 1'b0;
        shamtSrc = 1'b0;
        zeroExtImm = 1'b0;
        case (instr.r.opcode)
            opSpecial:
            begin
                regDst = 1'b1;
                case (instr.r.funct)
                    fnAdd:  aluOp = aluAdd;
                    fnAddu: aluOp = aluAddu;
                    fnSub:  aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnNor:  aluOp = aluNor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    fnMovn: aluOp = aluMovn;
                    fnMovz: aluOp = aluMovz;
                    fnSllv: aluOp = aluSll;
                    fnSrav: aluOp = aluSrav;
                    fnSrlv: aluOp = instr.r.shamt[0] ? aluRotr : aluSrl;  // ROTRV
                    fnSll:
                    begin
                        aluOp = aluSll;
                        shamtSrc = 1'b1;
                    end
                    fnSrl:
                    begin
                        aluOp = instr.r.rs[0] ? aluRotr : aluSrl;  // ROTR
                        shamtSrc = 1'b1;
                    end
                    fnSra:
                    begin
                        aluOp = aluSra;
                        shamtSrc = 1'b1;
                    end
                    default:
                    begin
                        hit = 1'b0;  // JR and HI/LO land here
                        regDst = 1'b0;
                    end
                endcase
            end
            opSpecial2:
            begin
                hit = instr.r.funct == fnMul;
                regDst = hit;
                aluOp = hit ? aluMul : aluNone;
            end
            opSpecial3:
            begin
                hit = (instr.r.funct == fnBshfl) &&
                      (instr.r.shamt == saSeb || instr.r.shamt == saSeh);
                regDst = hit;
                if (hit)
                    aluOp = (instr.r.shamt == saSeb) ? aluSeb : aluSeh;
            end
            // Immediate forms write rt
            opAddi:  aluOp = aluAdd;
            opAddiu: aluOp = aluAddu;
            opSlti:  aluOp = aluSlt;
            opSltiu: aluOp = aluSltiu;
            opAndi:  aluOp = aluAnd;
            opOri:   aluOp = aluOr;
            opXori:  aluOp = aluXor;
            default: hit = 1'b0;
        endcase

        if (hit && !regDst)
        begin
            aluSrcImm = 1'b1;
            zeroExtImm = (instr.i.opcode == opAndi) || (instr.i.opcode == opOri) ||
                         (instr.i.opcode == opXori);  // Logic immediates
        end
    end

endmodule

`default_nettype wire

/* source/memOpDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module memOpDecode
(
    input  mipsIsaPkg::instrWord_u                instr,
    output logic                                  hit,
    output logic                                  isLoad,
    output logic [mipsCtrlPkg::aluOpWidth-1:0]    aluOp,
    output logic [mipsCtrlPkg::memSizeWidth-1:0]  memRead,
    output logic [mipsCtrlPkg::memSizeWidth-1:0]  memWrite,
    output logic                                  zeroExtImm,
    output logic                                  aluSrcImm
);

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    always_comb
    begin
        hit = 1'b1;
        aluOp = aluMemAddr;
        memRead = memNone;
        memWrite = memNone;
        zeroExtImm = 1'b0;
        aluSrcImm = 1'b0;
        case (instr.i.opcode)
            opLw: memRead = memWord;
            opLh: memRead = memHalf;
            opLb: memRead = memByte;
            opSw: memWrite = memWord;
            opSh: memWrite = memHalf;
            opSb: memWrite = memByte;
            opLui:
            begin
                aluOp = aluLui;  // No memory access
                aluSrcImm = 1'b1;
                zeroExtImm = 1'b1;
            end
            default:
            begin
                hit = 1'b0;
                aluOp = aluNone;
            end
        endcase
        isLoad = memRead != memNone;
    end

endmodule

`default_nettype wire

/* source/branchDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module branchDecode
(
    input  mipsIsaPkg::instrWord_u              instr,
    output logic                                hit,
    output logic [mipsCtrlPkg::aluOpWidth-1:0]  aluOp,
    output logic                                pcRelative,
    output logic                                link,
    output logic                                jumpReg
);

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    always_comb
    begin
        aluOp = aluNone;
        link = 1'b0;
        jumpReg = 1'b0;
        case (instr.i.opcode)
            opBeq:  aluOp = aluBeq;
            opBne:  aluOp = aluBne;
            opBgtz: aluOp = aluBgtz;
            opBlez:
            begin
                if (instr.i.rt == '0)
                    aluOp = aluBlez;
            end
            opRegImm:
            begin
                if (instr.i.rt == rtBgez)
                    aluOp = aluBgez;
                else if (instr.i.rt == rtBltz)
                    aluOp = aluBltz;
            end
            opJ:   aluOp = aluJ;
            opJal:
            begin
                aluOp = aluJal;
                link = 1'b1;  // Return address to r31
            end
            opSpecial:
            begin
                if (instr.r.funct == fnJr)
                begin
                    aluOp = aluJr;
                    jumpReg = 1'b1;
                end
            end
            default: aluOp = aluNone;
        endcase
        // Every kept code here is nonzero
        hit = aluOp != aluNone;
        pcRelative = hit && !(link || jumpReg || instr.j.opcode == opJ);
    end

endmodule

`default_nettype wire

/* source/decodeControl.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeControl
(
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  instrValid,
    input  logic                                  aluHit,
    input  logic [mipsCtrlPkg::aluOpWidth-1:0]    aluCode,
    input  logic                                  aluRegDst,
    input  logic                                  aluImmOperand,
    input  logic                                  aluShamtSrc,
    input  logic                                  aluZeroExt,
    input  logic                                  memHit,
    input  logic                                  memIsLoad,
    input  logic [mipsCtrlPkg::aluOpWidth-1:0]    memCode,
    input  logic [mipsCtrlPkg::memSizeWidth-1:0]  memRdSize,
    input  logic [mipsCtrlPkg::memSizeWidth-1:0]  memWrSize,
    input  logic                                  memZeroExt,
    input  logic                                  memImmOperand,
    input  logic                                  brHit,
    input  logic [mipsCtrlPkg::aluOpWidth-1:0]    brCode,
    input  logic                                  brPcRelative,
    input  logic                                  brLink,
    input  logic                                  brJumpReg,
    output logic                                  ctrlValid,
    output logic                                  regWrite,
    output logic                                  regDst,
    output logic                                  aluSrcImm,
    output logic                                  shamtSrc,
    output logic                                  zeroExtImm,
    output logic [mipsCtrlPkg::aluOpWidth-1:0]    aluOp,
    output logic [mipsCtrlPkg::memSizeWidth-1:0]  memRead,
    output logic [mipsCtrlPkg::memSizeWidth-1:0]  memWrite,
    output logic                                  memToReg,
    output logic                                  branch,
    output logic                                  pcRelative,
    output logic                                  link,
    output logic                                  jumpReg,
    output logic                                  illegal
);

    import mipsCtrlPkg::*;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            ctrlValid <= 1'b0;
            illegal <= 1'b0;
            regWrite <= 1'b0;
            regDst <= 1'b0;
            aluSrcImm <= 1'b0;
            shamtSrc <= 1'b0;
            zeroExtImm <= 1'b0;
            aluOp <= aluNone;
            memRead <= memNone;
            memWrite <= memNone;
            memToReg <= 1'b0;
            branch <= 1'b0;
            pcRelative <= 1'b0;
            link <= 1'b0;
            jumpReg <= 1'b0;
        end
        else
        begin
            ctrlValid <= instrValid;
            illegal <= instrValid && !(aluHit || memHit || brHit);  // Unclaimed word
            // Idle or illegal cycles leave everything at zero
            regWrite <= 1'b0;
            regDst <= 1'b0;
            aluSrcImm <= 1'b0;
            shamtSrc <= 1'b0;
            zeroExtImm <= 1'b0;
            aluOp <= aluNone;
            memRead <= memNone;
            memWrite <= memNone;
            memToReg <= 1'b0;
            branch <= 1'b0;
            pcRelative <= 1'b0;
            link <= 1'b0;
            jumpReg <= 1'b0;
            if (instrValid && aluHit)
            begin
                regWrite <= 1'b1;
                regDst <= aluRegDst;
                aluSrcImm <= aluImmOperand;
                shamtSrc <= aluShamtSrc;
                zeroExtImm <= aluZeroExt;
                aluOp <= aluCode;
            end
            else if (instrValid && memHit)
            begin
                // LUI writes rt without a memory read
                regWrite <= memIsLoad || (memRdSize == memNone && memWrSize == memNone);
                memToReg <= memIsLoad;
                aluSrcImm <= memImmOperand;
                zeroExtImm <= memZeroExt;
                aluOp <= memCode;
                memRead <= memRdSize;
                memWrite <= memWrSize;
            end
            else if (instrValid && brHit)
            begin
                branch <= 1'b1;
                regWrite <= brLink;
                aluOp <= brCode;
                pcRelative <= brPcRelative;
                link <= brLink;
                jumpReg <= brJumpReg;
            end
        end
    end

endmodule

`default_nettype wire

/* source/mipsDecodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsDecodeStage
(
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  instrValid,
    input  logic [mipsIsaPkg::wordWidth-1:0]      instr,
    output logic                                  ctrlValid,
    output logic                                  regWrite,
    output logic                                  regDst,
    output logic                                  aluSrcImm,
    output logic                                  shamtSrc,
    output logic                                  zeroExtImm,
    output logic [mipsCtrlPkg::aluOpWidth-1:0]    aluOp,
    output logic [mipsCtrlPkg::memSizeWidth-1:0]  memRead,
    output logic [mipsCtrlPkg::memSizeWidth-1:0]  memWrite,
    output logic                                  memToReg,
    output logic                                  branch,
    output logic                                  pcRelative,
    output logic                                  link,
    output logic                                  jumpReg,
    output logic                                  illegal
);

    import mipsCtrlPkg::*;

    ////////////////////////////////////////
    // Group decoder results
    ////////////////////////////////////////
    logic                    aluHit;
    logic [aluOpWidth-1:0]   aluCode;
    logic                    aluRegDst;
    logic                    aluImmOperand;
    logic                    aluShamtSrc;
    logic                    aluZeroExt;
    logic                    memHit;
    logic                    memIsLoad;
    logic [aluOpWidth-1:0]   memCode;
    logic [memSizeWidth-1:0] memRdSize;
    logic [memSizeWidth-1:0] memWrSize;
    logic                    memZeroExt;
    logic                    memImmOperand;
    logic                    brHit;
    logic [aluOpWidth-1:0]   brCode;
    logic                    brPcRelative;
    logic                    brLink;
    logic                    brJumpReg;

    aluOpDecode i_aluOpDecode
    (
        .instr      (instr),
        .hit        (aluHit),
        .aluOp      (aluCode),
        .regDst     (aluRegDst),
        .aluSrcImm  (aluImmOperand),
        .shamtSrc   (aluShamtSrc),
        .zeroExtImm (aluZeroExt)
    );

    memOpDecode i_memOpDecode
    (
        .instr      (instr),
        .hit        (memHit),
        .isLoad     (memIsLoad),
        .aluOp      (memCode),
        .memRead    (memRdSize),
        .memWrite   (memWrSize),
        .zeroExtImm (memZeroExt),
        .aluSrcImm  (memImmOperand)
    );

    branchDecode i_branchDecode
    (
        .instr      (instr),
        .hit        (brHit),
        .aluOp      (brCode),
        .pcRelative (brPcRelative),
        .link       (brLink),
        .jumpReg    (brJumpReg)
    );

    decodeControl i_decodeControl
    (
        .clk           (clk),
        .rstN          (rstN),
        .instrValid    (instrValid),
        .aluHit        (aluHit),
        .aluCode       (aluCode),
        .aluRegDst     (aluRegDst),
        .aluImmOperand (aluImmOperand),
        .aluShamtSrc   (aluShamtSrc),
        .aluZeroExt    (aluZeroExt),
        .memHit        (memHit),
        .memIsLoad     (memIsLoad),
        .memCode       (memCode),
        .memRdSize     (memRdSize),
        .memWrSize     (memWrSize),
        .memZeroExt    (memZeroExt),
        .memImmOperand (memImmOperand),
        .brHit         (brHit),
        .brCode        (brCode),
        .brPcRelative  (brPcRelative),
        .brLink        (brLink),
        .brJumpReg     (brJumpReg),
        .ctrlValid     (ctrlValid),
        .regWrite      (regWrite),
        .regDst        (regDst),
        .aluSrcImm     (aluSrcImm),
        .shamtSrc      (shamtSrc),
        .zeroExtImm    (zeroExtImm),
        .aluOp         (aluOp),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .memToReg      (memToReg),
        .branch        (branch),
        .pcRelative    (pcRelative),
        .link          (link),
        .jumpReg       (jumpReg),
        .illegal       (illegal)
    );

endmodule

`default_nettype wire

/* dv/mipsDecodeStageTb.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsDecodeStageTb;

    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    localparam int numCases    = 49;
    localparam int numCols     = 16;
    localparam int resetCycles = 5;
    localparam int maxGap      = 2;  // Idle cycles after a case
    localparam int cycleLimit  = resetCycles + numCases * (maxGap + 1) + 20;

    // Columns of one case line
    localparam int colValid    = 0;
    localparam int colInstr    = 1;
    localparam int colIllegal  = 2;
    localparam int colRegWrite = 3;
    localparam int colRegDst   = 4;
    localparam int colImm      = 5;
    localparam int colShamt    = 6;
    localparam int colZeroExt  = 7;
    localparam int colAluOp    = 8;
    localparam int colMemRead  = 9;
    localparam int colMemWrite = 10;
    localparam int colMemToReg = 11;
    localparam int colBranch   = 12;
    localparam int colPcRel    = 13;
    localparam int colLink     = 14;
    localparam int colJumpReg  = 15;

    logic                    clk;
    logic                    rstN;
    logic                    instrValid;
    logic [wordWidth-1:0]    instr;
    logic                    ctrlValid;
    logic                    regWrite;
    logic                    regDst;
    logic                    aluSrcImm;
    logic                    shamtSrc;
    logic                    zeroExtImm;
    logic [aluOpWidth-1:0]   aluOp;
    logic [memSizeWidth-1:0] memRead;
    logic [memSizeWidth-1:0] memWrite;
    logic                    memToReg;
    logic                    branch;
    logic                    pcRelative;
    logic                    link;
    logic                    jumpReg;
    logic                    illegal;

    logic [31:0] caseMem [0:numCases*numCols-1];
    logic [31:0] expRow [0:numCols-1];
    integer      seed;
    int          cycleCount;
    int          passCount;
    int          failCount;
    int          caseErrors;

    mipsDecodeStage i_mipsDecodeStage
    (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .regWrite   (regWrite),
        .regDst     (regDst),
        .aluSrcImm  (aluSrcImm),
        .shamtSrc   (shamtSrc),
        .zeroExtImm (zeroExtImm),
        .aluOp      (aluOp),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memToReg   (memToReg),
        .branch     (branch),
        .pcRelative (pcRelative),
        .link       (link),
        .jumpReg    (jumpReg),
        .illegal    (illegal)
    );

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("run timed out after %0d cycles before all cases were checked", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
            caseErrors++;
        end
    endtask

    task automatic checkAluOp(input string name, input logic [aluOpWidth-1:0] expected,
                              input logic [aluOpWidth-1:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
            caseErrors++;
        end
    endtask

    task automatic checkMemSize(input string name, input logic [memSizeWidth-1:0] expected,
                                input logic [memSizeWidth-1:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
            caseErrors++;
        end
    endtask

    task automatic loadExpected(input int idx);
        for (int c = 0; c < numCols; c++)
            expRow[c] = caseMem[idx*numCols + c];
    endtask

    task automatic clearExpected();
        for (int c = 0; c < numCols; c++)
            expRow[c] = '0;
    endtask

    task automatic compareOutputs(input string label);
        caseErrors = 0;
        checkFlag("ctrlValid", expRow[colValid][0], ctrlValid);
        checkFlag("illegal", expRow[colIllegal][0], illegal);
        checkFlag("regWrite", expRow[colRegWrite][0], regWrite);
        checkFlag("regDst", expRow[colRegDst][0], regDst);
        checkFlag("aluSrcImm", expRow[colImm][0], aluSrcImm);
        checkFlag("shamtSrc", expRow[colShamt][0], shamtSrc);
        checkFlag("zeroExtImm", expRow[colZeroExt][0], zeroExtImm);
        checkAluOp("aluOp", expRow[colAluOp][aluOpWidth-1:0], aluOp);
        checkMemSize("memRead", expRow[colMemRead][memSizeWidth-1:0], memRead);
        checkMemSize("memWrite", expRow[colMemWrite][memSizeWidth-1:0], memWrite);
        checkFlag("memToReg", expRow[colMemToReg][0], memToReg);
        checkFlag("branch", expRow[colBranch][0], branch);
        checkFlag("pcRelative", expRow[colPcRel][0], pcRelative);
        checkFlag("link", expRow[colLink][0], link);
        checkFlag("jumpReg", expRow[colJumpReg][0], jumpReg);
        if (caseErrors == 0)
        begin
            passCount++;
            $display("%s passed", label);
        end
        else
        begin
            failCount++;
            $display("%s failed with %0d errors", label, caseErrors);
        end
    endtask

    ////////////////////////////////////////
    // Back-to-back run with random gaps
    ////////////////////////////////////////
    task automatic runCases();
        int    next;
        int    gapLeft;
        int    pending;  // Checked at next edge, -1 idle, -2 nothing
        bit    done;
        string label;
        next = 0;
        gapLeft = 0;
        pending = -2;
        done = 1'b0;
        while (!done)
        begin
            if (pending >= 0)
            begin
                loadExpected(pending);
                label = $sformatf("case %0d instr 0x%h", pending,
                                  caseMem[pending*numCols + colInstr]);
                compareOutputs(label);
            end
            else if (pending == -1)
            begin
                clearExpected();
                compareOutputs("idle cycle");
            end
            if (next >= numCases)
            begin
                instrValid = 1'b0;
                instr = '0;
                done = 1'b1;
            end
            else if (gapLeft > 0)
            begin
                instrValid = 1'b0;
                instr = $random(seed);  // Ignored while not valid
                gapLeft--;
                pending = -1;
            end
            else
            begin
                instrValid = caseMem[next*numCols + colValid][0];
                instr = caseMem[next*numCols + colInstr];
                pending = next;
                next++;
                gapLeft = $unsigned($random(seed)) % (maxGap + 1);
            end
            if (!done)
            begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial
    begin
        clk = 1'b0;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        seed = 65;
        cycleCount = 0;
        passCount = 0;
        failCount = 0;
        caseErrors = 0;
        $readmemh("dv/decodeCases.txt", caseMem);

        repeat (resetCycles) @(posedge clk);
        #1;
        clearExpected();
        compareOutputs("reset state");  // Nothing decoded yet
        rstN = 1'b1;

        runCases();

        $display("checks finished: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/decodeCases.txt */
// valid instr illegal regWrite regDst aluSrcImm shamtSrc zeroExtImm aluOp memRead memWrite
// memToReg branch pcRelative link jumpReg, all hex, one case per line
1 00221820 0 1 1 0 0 0 00 0 0 0 0 0 0 0 // ADD
1 00221821 0 1 1 0 0 0 17 0 0 0 0 0 0 0 // ADDU
1 00221822 0 1 1 0 0 0 01 0 0 0 0 0 0 0 // SUB
1 00221824 0 1 1 0 0 0 02 0 0 0 0 0 0 0 // AND
1 00221825 0 1 1 0 0 0 03 0 0 0 0 0 0 0 // OR
1 00221826 0 1 1 0 0 0 05 0 0 0 0 0 0 0 // XOR
1 00221827 0 1 1 0 0 0 04 0 0 0 0 0 0 0 // NOR
1 0022182a 0 1 1 0 0 0 09 0 0 0 0 0 0 0 // SLT
1 0022182b 0 1 1 0 0 0 11 0 0 0 0 0 0 0 // SLTU
1 0022180b 0 1 1 0 0 0 0a 0 0 0 0 0 0 0 // MOVN
1 0022180a 0 1 1 0 0 0 0b 0 0 0 0 0 0 0 // MOVZ
1 00021900 0 1 1 0 1 0 07 0 0 0 0 0 0 0 // SLL
1 00021902 0 1 1 0 1 0 08 0 0 0 0 0 0 0 // SRL
1 00221902 0 1 1 0 1 0 0c 0 0 0 0 0 0 0 // ROTR
1 00021903 0 1 1 0 1 0 0d 0 0 0 0 0 0 0 // SRA
1 00221804 0 1 1 0 0 0 07 0 0 0 0 0 0 0 // SLLV
1 00221806 0 1 1 0 0 0 08 0 0 0 0 0 0 0 // SRLV
1 00221846 0 1 1 0 0 0 0c 0 0 0 0 0 0 0 // ROTRV
1 00221807 0 1 1 0 0 0 0e 0 0 0 0 0 0 0 // SRAV
1 70221802 0 1 1 0 0 0 12 0 0 0 0 0 0 0 // MUL
1 7c021c20 0 1 1 0 0 0 0f 0 0 0 0 0 0 0 // SEB
1 7c021e20 0 1 1 0 0 0 06 0 0 0 0 0 0 0 // SEH
1 20220010 0 1 0 1 0 0 00 0 0 0 0 0 0 0 // ADDI
1 24220010 0 1 0 1 0 0 17 0 0 0 0 0 0 0 // ADDIU
1 28220010 0 1 0 1 0 0 09 0 0 0 0 0 0 0 // SLTI
1 2c220010 0 1 0 1 0 0 10 0 0 0 0 0 0 0 // SLTIU
1 30220010 0 1 0 1 0 1 02 0 0 0 0 0 0 0 // ANDI
1 34220010 0 1 0 1 0 1 03 0 0 0 0 0 0 0 // ORI
1 38220010 0 1 0 1 0 1 05 0 0 0 0 0 0 0 // XORI
1 3c020010 0 1 0 1 0 1 21 0 0 0 0 0 0 0 // LUI
1 8c220010 0 1 0 0 0 0 24 1 0 1 0 0 0 0 // LW
1 84220010 0 1 0 0 0 0 24 2 0 1 0 0 0 0 // LH
1 80220010 0 1 0 0 0 0 24 3 0 1 0 0 0 0 // LB
1 ac220010 0 0 0 0 0 0 24 0 1 0 0 0 0 0 // SW
1 a4220010 0 0 0 0 0 0 24 0 2 0 0 0 0 0 // SH
1 a0220010 0 0 0 0 0 0 24 0 3 0 0 0 0 0 // SB
1 10220004 0 0 0 0 0 0 1c 0 0 0 1 1 0 0 // BEQ
1 14220004 0 0 0 0 0 0 1d 0 0 0 1 1 0 0 // BNE
1 1c200004 0 0 0 0 0 0 1e 0 0 0 1 1 0 0 // BGTZ
1 18200004 0 0 0 0 0 0 1f 0 0 0 1 1 0 0 // BLEZ
1 04210004 0 0 0 0 0 0 20 0 0 0 1 1 0 0 // BGEZ
1 04200004 0 0 0 0 0 0 25 0 0 0 1 1 0 0 // BLTZ
1 08000100 0 0 0 0 0 0 26 0 0 0 1 0 0 0 // J
1 0c000100 0 1 0 0 0 0 23 0 0 0 1 0 1 0 // JAL
1 03e00008 0 0 0 0 0 0 22 0 0 0 1 0 0 1 // JR
1 00220018 1 0 0 0 0 0 00 0 0 0 0 0 0 0 // MULT, dropped
1 00001810 1 0 0 0 0 0 00 0 0 0 0 0 0 0 // MFHI, dropped
1 70220000 1 0 0 0 0 0 00 0 0 0 0 0 0 0 // MADD, dropped
0 00221820 0 0 0 0 0 0 00 0 0 0 0 0 0 0 // ADD word without valid

/* mipsDecodeStage.f */
source/mipsIsaPkg.sv
source/mipsCtrlPkg.sv
source/aluOpDecode.sv
source/memOpDecode.sv
source/branchDecode.sv
source/decodeControl.sv
source/mipsDecodeStage.sv
dv/mipsDecodeStageTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module mipsDecodeStageTb \
    -f mipsDecodeStage.f -o mipsDecodeStageSim > build.log 2>&1 \
    && ./obj_dir/mipsDecodeStageSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
